//--- filelist.f
+incdir+src
src/video_pkg.sv
src/raster_control.sv
src/sync_gen.sv
src/pixel_output.sv
src/video_top.sv
verif/tb_video.sv

//--- run_sim.sh
#!/bin/sh
# Builds the video timing testbench with Verilator and runs it.
# The run counts as passed only if the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_video -Mdir obj_dir -f filelist.f \
  && ./obj_dir/Vtb_video | tee /dev/stderr | grep -x "sim passed" > /dev/null \
  && echo "run_sim: simulation reported success" \
  || { echo "run_sim: build error or simulation reported failure"; exit 1; }

//--- src/pixel_output.sv
module pixel_output
(
  input  logic                     clk,
  input  logic                     reset_n,
  input  video_pkg::raster_flags_t flags,
  input  video_pkg::rgb4_t         pixel_in,
  output video_pkg::video_out_t    video_out
);

  import video_pkg::*;

  // Full scale on all three channels for the frame
  localparam rgb8_t RGB_WHITE = '1;

  logic  de_next;
  logic  border;
  rgb8_t widened;

  // Repeating the nibble maps 0x0 to 0x00 and 0xF to 0xFF, so the
  // full input range stretches evenly over the output range
  function automatic channel_t widen(input nibble_t n);
    return {n, n};
  endfunction

  // ==================================================
  // Enable and border select
  // ==================================================

  // Data enable needs both windows open in the same cycle
  assign de_next = flags.h_act & flags.v_act;

  // Edge flags are only meaningful inside the picture
  assign border = de_next & (flags.h_edge | flags.v_edge);

  // ==================================================
  // Colour widening
  // ==================================================

  assign widened = '{r: widen(pixel_in.r), g: widen(pixel_in.g), b: widen(pixel_in.b)};

  // ==================================================
  // Output register
  // ==================================================

  // One stage for the whole bus keeps syncs, enable and colour aligned
  // and gives an input to output latency of one clock
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      video_out.hs  <= 1'b1;
      video_out.vs  <= 1'b1;
      video_out.de  <= 1'b0;
      video_out.rgb <= '0;
    end
    else
    begin
      video_out.hs <= flags.hs;
      video_out.vs <= flags.vs;
      video_out.de <= de_next;
      // Outside the frame the input passes straight through, also in
      // blanking where the sink ignores it
      if (border)
        video_out.rgb <= RGB_WHITE;
      else
        video_out.rgb <= widened;
    end
  end

endmodule

//--- src/raster_control.sv
`include "video_defines.svh"

module raster_control
(
  input  logic                   clk,
  input  logic                   reset_n,
  output video_pkg::raster_pos_t pos
);

  import video_pkg::*;

  // line_end is registered, so it is raised one count before the last one
  localparam coord_t H_PRE_LAST = coord_t'(`H_TOTAL - 2);
  localparam coord_t V_LAST     = coord_t'(`V_TOTAL - 1);

  // Lines at which the vertical counter enters and leaves the picture
  localparam coord_t V_OPEN  = coord_t'(`V_ACT_START);
  localparam coord_t V_CLOSE = coord_t'(`V_ACT_END);

  coord_t      h_count;
  coord_t      v_count;
  logic        line_end;
  logic        frame_end;
  logic        line_end_next;
  logic        frame_end_next;
  raster_fsm_t state;
  raster_fsm_t state_next;

  // ==================================================
  // Frame state
  // ==================================================

  // The state moves only at the end of a line, together with v_count
  always_comb
  begin
    state_next = state;
    if (line_end)
    begin
      case (state)
        FRAME_BLANK:
          if (v_count == V_OPEN)
            state_next = FRAME_ACTIVE;
        FRAME_ACTIVE:
          if (v_count == V_CLOSE)
            state_next = FRAME_BLANK;
        default:
          state_next = FRAME_BLANK;
      endcase
    end
  end

  // A frame can only finish during blanking, so the last-line compare
  // is qualified by the state and never toggles inside the picture
  assign line_end_next  = (h_count == H_PRE_LAST);
  assign frame_end_next = line_end_next && (state == FRAME_BLANK) && (v_count == V_LAST);

  // ==================================================
  // Counters
  // ==================================================

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      h_count   <= '0;
      v_count   <= '0;
      line_end  <= 1'b0;
      frame_end <= 1'b0;
      state     <= FRAME_BLANK;
    end
    else
    begin
      state     <= state_next;
      line_end  <= line_end_next;
      frame_end <= frame_end_next;
      // Horizontal wraps on every line end, vertical only on frame end
      if (line_end)
      begin
        h_count <= '0;
        if (frame_end)
          v_count <= '0;
        else
          v_count <= v_count + coord_t'(1);
      end
      else
      begin
        h_count <= h_count + coord_t'(1);
      end
    end
  end

  assign pos = '{h_count: h_count, v_count: v_count, line_end: line_end, frame_end: frame_end};

endmodule

//--- src/sync_gen.sv
`include "video_defines.svh"

module sync_gen
(
  input  logic                     clk,
  input  logic                     reset_n,
  input  video_pkg::raster_pos_t   pos,
  output video_pkg::raster_flags_t flags
);

  import video_pkg::*;

  // Sync is low from the last count of the period up to these counts
  localparam coord_t H_SYNC_END = coord_t'(`H_PULSE - 1);
  localparam coord_t V_SYNC_END = coord_t'(`V_PULSE - 1);

  // Active window bounds, the horizontal one already shifted early
  localparam coord_t H_OPEN     = coord_t'(`H_ACT_START);
  localparam coord_t H_CLOSE    = coord_t'(`H_ACT_END);
  localparam coord_t H_LAST_COL = coord_t'(`H_ACT_END - 1);
  localparam coord_t V_OPEN     = coord_t'(`V_ACT_START);
  localparam coord_t V_CLOSE    = coord_t'(`V_ACT_END);
  localparam coord_t V_LAST_ROW = coord_t'(`V_ACT_END - 1);

  logic hs_q;
  logic vs_q;
  logic h_act_q;
  logic v_act_q;
  logic h_edge_q;
  logic v_edge_q;

  // ==================================================
  // Horizontal decode
  // ==================================================

  // hs covers the last count of the line plus counts 0 to 38, which
  // after the register gives a 40 clock low pulse
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      hs_q     <= 1'b1;
      h_act_q  <= 1'b0;
      h_edge_q <= 1'b0;
    end
    else
    begin
      hs_q <= !(pos.line_end || (pos.h_count < H_SYNC_END));
      if (pos.h_count == H_OPEN)
        h_act_q <= 1'b1;
      else if (pos.h_count == H_CLOSE)
        h_act_q <= 1'b0;
      // First and last clock of the active window form the side border
      h_edge_q <= (pos.h_count == H_OPEN) || (pos.h_count == H_LAST_COL);
    end
  end

  // ==================================================
  // Vertical decode
  // ==================================================

  // Everything vertical moves once per line, at the line end
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      vs_q     <= 1'b1;
      v_act_q  <= 1'b0;
      v_edge_q <= 1'b0;
    end
    else if (pos.line_end)
    begin
      vs_q <= !(pos.frame_end || (pos.v_count < V_SYNC_END));
      if (pos.v_count == V_OPEN)
        v_act_q <= 1'b1;
      else if (pos.v_count == V_CLOSE)
        v_act_q <= 1'b0;
      // Whole first and last active line form the top and bottom border
      v_edge_q <= (pos.v_count == V_OPEN) || (pos.v_count == V_LAST_ROW);
    end
  end

  assign flags = '{hs: hs_q, vs: vs_q, h_act: h_act_q, v_act: v_act_q,
                   h_edge: h_edge_q, v_edge: v_edge_q};

endmodule

//--- src/video_defines.svh
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// ==================================================
// Mode timing for the fixed 256 x 256 raster
// ==================================================

// Horizontal timing in pixel clocks
`define H_DISPLAY 256
`define H_FP      8
`define H_PULSE   40
`define H_BP      16

// Vertical timing in whole lines
`define V_DISPLAY 256
`define V_FP      8
`define V_PULSE   7
`define V_BP      16

// Counter and colour channel widths
`define COORD_W   12
`define NIBBLE_W  4
`define CHANNEL_W 8

// The output stage adds two register stages after the counters, so the
// horizontal active window is opened this many clocks early to line up
// with the delayed sync pulses
`define PIPE_LEAD 2

// Derived totals, 320 clocks per line and 287 lines per frame
`define H_TOTAL (`H_DISPLAY + `H_FP + `H_PULSE + `H_BP)
`define V_TOTAL (`V_DISPLAY + `V_FP + `V_PULSE + `V_BP)

// Counts at which the active windows open and close
`define H_ACT_START (`H_PULSE + `H_BP - 1 - `PIPE_LEAD)
`define H_ACT_END   (`H_ACT_START + `H_DISPLAY)
`define V_ACT_START (`V_PULSE + `V_BP - 1)
`define V_ACT_END   (`V_ACT_START + `V_DISPLAY)

`endif

//--- src/video_pkg.sv
`include "video_defines.svh"

package video_pkg;

  // ==================================================
  // Plain vector types
  // ==================================================

  // Raster counter value, wide enough for any supported total
  typedef logic [`COORD_W-1:0] coord_t;

  // One input colour channel as it arrives from the pixel source
  typedef logic [`NIBBLE_W-1:0] nibble_t;

  // One output colour channel after widening
  typedef logic [`CHANNEL_W-1:0] channel_t;

  // ==================================================
  // Bundles passed between the blocks
  // ==================================================

  // Input pixel, 12 bits
  typedef struct packed {
    nibble_t r;
    nibble_t g;
    nibble_t b;
  } rgb4_t;

  // Output pixel, 24 bits
  typedef struct packed {
    channel_t r;
    channel_t g;
    channel_t b;
  } rgb8_t;

  // Raster position as owned by the counter controller
  // line_end and frame_end are high on the last count they mark
  typedef struct packed {
    coord_t h_count;
    coord_t v_count;
    logic   line_end;
    logic   frame_end;
  } raster_pos_t;

  // Decoded timing flags, one clock behind the position
  typedef struct packed {
    logic hs;
    logic vs;
    logic h_act;
    logic v_act;
    logic h_edge;
    logic v_edge;
  } raster_flags_t;

  // Final video bus, syncs are active low
  typedef struct packed {
    logic  hs;
    logic  vs;
    logic  de;
    rgb8_t rgb;
  } video_out_t;

  // Whether the vertical counter sits inside the active lines
  typedef enum logic {
    FRAME_BLANK  = 1'b0,
    FRAME_ACTIVE = 1'b1
  } raster_fsm_t;

endpackage

//--- src/video_top.sv
module video_top
(
  input  logic                  clk,
  input  logic                  reset_n,
  input  video_pkg::rgb4_t      pixel_in,
  output video_pkg::video_out_t video_out
);

  import video_pkg::*;

  // Raster position from the counter controller
  raster_pos_t   pos;

  // Decoded sync and window flags, one clock behind pos
  raster_flags_t flags;

  // ==================================================
  // Timing chain
  // ==================================================

  // Free running line and frame counters
  raster_control u_raster_control
  (
    .clk     (clk),
    .reset_n (reset_n),
    .pos     (pos)
  );

  // Sync pulses, active windows and border edges
  sync_gen u_sync_gen
  (
    .clk     (clk),
    .reset_n (reset_n),
    .pos     (pos),
    .flags   (flags)
  );

  // Final register stage with the colour path
  pixel_output u_pixel_output
  (
    .clk       (clk),
    .reset_n   (reset_n),
    .flags     (flags),
    .pixel_in  (pixel_in),
    .video_out (video_out)
  );

endmodule

//--- verif/tb_video.sv
module tb_video;

  timeunit 1ns;
  timeprecision 100ps;

  import video_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int NUM_TESTS    = 5;

  logic       clk;
  logic       reset_n;
  rgb4_t      pixel_in;
  video_out_t video_out;

  // Timing words and colour words from the data file
  logic [31:0] tdata [0:21];
  logic [11:0] colour_words [0:15];
  int          line_period;
  int          hs_width;
  int          frame_lines;
  int          vs_width;
  int          active_px;
  int          active_lines;
  logic        constants_loaded;

  // Stimulus state where sampled_word is the word the DUT took at the last edge
  logic [31:0] rng_state;
  logic [3:0]  word_idx;
  logic [11:0] drive_word;
  logic [11:0] sampled_word;

  // Monitor state
  int   cycle;
  logic hs_prev;
  logic vs_prev;
  logic de_prev;
  int   hs_falls;
  int   vs_falls;
  int   vs_rises;
  int   hs_fall_cycle;
  int   vs_fall_cycle;
  int   run_len;
  int   line_idx;
  int   de_lines;
  logic first_de_seen;

  // Mismatch count per test and the closing tally
  int    test_errors [1:NUM_TESTS];
  string test_names [1:NUM_TESTS];
  int    tests_passed;
  int    tests_failed;

  video_top DUT
  (
    .clk       (clk),
    .reset_n   (reset_n),
    .pixel_in  (pixel_in),
    .video_out (video_out)
  );

  // ==================================================
  // Helpers
  // ==================================================

  // 32-bit xorshift with the shift triple 13, 17 and 5
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Writing a nibble twice is the same as scaling it by 17
  function automatic logic [23:0] widen_rgb(input logic [11:0] w);
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    r = 8'(w[11:8]) * 8'd17;
    g = 8'(w[7:4]) * 8'd17;
    b = 8'(w[3:0]) * 8'd17;
    return {r, g, b};
  endfunction

  task automatic check_equal(input int test_id, input string what,
                             input logic [31:0] got, input logic [31:0] expected);
    if (got !== expected)
    begin
      test_errors[test_id]++;
      $display("FAILED at %0d ns: test %0d, %s: got 0x%0h, expected 0x%0h",
               $time, test_id, what, got, expected);
    end
  endtask

  // ==================================================
  // Clock and stimulus
  // ==================================================

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // A new colour word goes out every clock and the previous one is what
  // the DUT just sampled
  always @(posedge clk)
  begin
    sampled_word = drive_word;
    rng_state = xorshift32(rng_state);
    drive_word = colour_words[word_idx] ^ rng_state[11:0];
    word_idx = word_idx + 4'd1;
    pixel_in <= drive_word;
  end

  // ==================================================
  // Output monitor
  // ==================================================

  // Outputs change on the rising edge, so they are read on the falling one
  always @(negedge clk)
  begin
    if (reset_n)
    begin
      cycle++;
      // The first hs pulse after reset is short and is not measured
      if (!video_out.hs && hs_prev)
      begin
        hs_falls++;
        if (hs_falls >= 3)
          check_equal(2, "hs period", cycle - hs_fall_cycle, line_period);
        hs_fall_cycle = cycle;
      end
      if (video_out.hs && !hs_prev && hs_falls >= 2)
        check_equal(2, "hs low width", cycle - hs_fall_cycle, hs_width);
      // A vs fall ends the frame and closes its count of lines with de
      if (!video_out.vs && vs_prev)
      begin
        vs_falls++;
        if (vs_falls >= 3)
          check_equal(2, "vs period", cycle - vs_fall_cycle, frame_lines * line_period);
        if (vs_falls >= 2)
          check_equal(3, "lines with de per frame", de_lines, active_lines);
        vs_fall_cycle = cycle;
        de_lines = 0;
        line_idx = -1;
      end
      if (video_out.vs && !vs_prev)
      begin
        vs_rises++;
        if (vs_falls >= 2)
          check_equal(2, "vs low width", cycle - vs_fall_cycle, vs_width * line_period);
      end
      // Start of an active run
      if (video_out.de && !de_prev)
      begin
        run_len = 0;
        line_idx++;
        de_lines++;
        if (!first_de_seen)
        begin
          first_de_seen = 1'b1;
          check_equal(1, "vs pulse ends before first de", {31'd0, vs_rises > 0}, 32'd1);
        end
      end
      // Border pixels are white and all other pixels carry the widened input
      if (video_out.de)
      begin
        if (run_len == 0 || run_len == active_px - 1 ||
            line_idx == 0 || line_idx == active_lines - 1)
          check_equal(5, "border pixel", {8'd0, video_out.rgb}, 32'h00ff_ffff);
        else
          check_equal(4, "picture pixel", {8'd0, video_out.rgb},
                      {8'd0, widen_rgb(sampled_word)});
        run_len++;
      end
      if (!video_out.de && de_prev)
        check_equal(3, "de run length", run_len, active_px);
      hs_prev = video_out.hs;
      vs_prev = video_out.vs;
      de_prev = video_out.de;
    end
  end

  // ==================================================
  // Watchdog
  // ==================================================

  // Two frames plus reset with ten percent of margin
  initial
  begin
    int limit_cycles;
    wait (constants_loaded);
    limit_cycles = (2 * line_period * frame_lines + RESET_CYCLES) * 11 / 10;
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout: two full frames did not appear within %0d clock cycles",
             limit_cycles);
    $display("sim failed");
    $finish;
  end

  // ==================================================
  // Main sequence
  // ==================================================

  initial
  begin
    reset_n = 1'b0;
    pixel_in = '0;
    constants_loaded = 1'b0;
    rng_state = 32'h75c4;
    word_idx = 4'd0;
    drive_word = 12'h000;
    sampled_word = 12'h000;
    cycle = 0;
    hs_prev = 1'b1;
    vs_prev = 1'b1;
    de_prev = 1'b0;
    hs_falls = 0;
    vs_falls = 0;
    vs_rises = 0;
    hs_fall_cycle = 0;
    vs_fall_cycle = 0;
    run_len = 0;
    line_idx = -1;
    de_lines = 0;
    first_de_seen = 1'b0;
    tests_passed = 0;
    tests_failed = 0;
    test_names[1] = "reset state and first blanking";
    test_names[2] = "hs and vs period and width";
    test_names[3] = "de run length and line count";
    test_names[4] = "picture pixels";
    test_names[5] = "white border";
    for (int t = 1; t <= NUM_TESTS; t++)
      test_errors[t] = 0;

    $readmemh("verif/video_testdata.txt", tdata);
    line_period  = int'(tdata[0]);
    hs_width     = int'(tdata[1]);
    frame_lines  = int'(tdata[2]);
    vs_width     = int'(tdata[3]);
    active_px    = int'(tdata[4]);
    active_lines = int'(tdata[5]);
    for (int i = 0; i < 16; i++)
      colour_words[i] = tdata[6 + i][11:0];
    constants_loaded = 1'b1;

    // Reset values are checked inside reset and again after the first
    // active edge, which carries the reset values of the flags to the bus
    repeat (RESET_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check_equal(1, "hs in reset", {31'd0, video_out.hs}, 32'd1);
    check_equal(1, "vs in reset", {31'd0, video_out.vs}, 32'd1);
    check_equal(1, "de in reset", {31'd0, video_out.de}, 32'd0);
    check_equal(1, "rgb in reset", {8'd0, video_out.rgb}, 32'd0);
    @(posedge clk);
    reset_n <= 1'b1;
    repeat (2) @(negedge clk);
    check_equal(1, "hs after release", {31'd0, video_out.hs}, 32'd1);
    check_equal(1, "vs after release", {31'd0, video_out.vs}, 32'd1);
    check_equal(1, "de after release", {31'd0, video_out.de}, 32'd0);

    // The third vs pulse closes the second full frame
    wait (vs_falls >= 3);
    repeat (2) @(posedge clk);

    for (int t = 1; t <= NUM_TESTS; t++)
    begin
      if (test_errors[t] == 0)
      begin
        tests_passed++;
        $display("test %0d %s: ok", t, test_names[t]);
      end
      else
      begin
        tests_failed++;
        $display("test %0d %s: %0d mismatches", t, test_names[t], test_errors[t]);
      end
    end
    $display("tests ok: %0d, tests with mismatches: %0d", tests_passed, tests_failed);
    if (tests_failed == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

//--- verif/video_testdata.txt
// Timing words in order: line period, hs width, frame lines, vs width,
// active pixels per line, active lines; then 16 colour words as 0xRGB
140
28
11f
7
100
100
// Colour words, XORed with the random stream before they are driven
000
fff
f00
0f0
00f
ff0
0ff
f0f
123
456
789
abc
def
5a5
a5a
c3e
